/* displayPipe.f */
verilog/displayPkg.sv
verilog/fifoReadIf.sv
verilog/pixelFifoMem.sv
verilog/grayPtrSync.sv
verilog/pixelFifo.sv
verilog/videoTimingCtrl.sv
verilog/displayPipe.sv
test/displayPipeChecker.sv
test/displayPipeTb.sv

/* test/displayPipeTb.sv */
module displayPipeTb;
    timeunit 1ns;
    timeprecision 100ps;
    import displayPkg::*;

    localparam int tableSize = 40;
    localparam int fillCount = 16;
    localparam pixelT blockedPixel = 24'hDEAD00;

    typedef enum {fillPhase, streamPhase} phaseT;

    typedef struct {
        pixelT pixel;
        phaseT phase;
    } stimT;

    logic  iPixelClk;
    logic  sysClk;
    logic  reset;
    pixelT pixelIn;
    logic  writeEn;
    logic  full;
    pixelT pixelOut;
    logic  dataEnable;
    logic  hSyncOut;
    logic  vSyncOut;
    logic  underflow;

    // write table whose order is also the display order
    stimT        stim[tableSize];
    logic [15:0] lfsr;

    // ----------------------------------------
    // clocks
    // ----------------------------------------
    initial
    begin
        iPixelClk = 1'b0;
        forever #20 iPixelClk = ~iPixelClk;
    end

    initial
    begin
        sysClk = 1'b0;
        forever #15 sysClk = ~sysClk;
    end

    displayPipe #(
        .fifoDepth (16),
        .hActive   (8),
        .hFront    (2),
        .hSync     (2),
        .hBack     (2),
        .vActive   (4),
        .vFront    (1),
        .vSync     (1),
        .vBack     (1)
    ) DUT (
        .sysClk     (sysClk),
        .iPixelClk  (iPixelClk),
        .reset      (reset),
        .pixelIn    (pixelIn),
        .writeEn    (writeEn),
        .full       (full),
        .pixelOut   (pixelOut),
        .dataEnable (dataEnable),
        .hSyncOut   (hSyncOut),
        .vSyncOut   (vSyncOut),
        .underflow  (underflow)
    );

    displayPipeChecker #(
        .hActive      (8),
        .hFront       (2),
        .hSync        (2),
        .hBack        (2),
        .vSync        (1),
        .fifoDepth    (fillCount),
        .blockedPixel (blockedPixel)
    ) monitor (
        .iPixelClk  (iPixelClk),
        .sysClk     (sysClk),
        .reset      (reset),
        .pixelIn    (pixelIn),
        .writeEn    (writeEn),
        .full       (full),
        .pixelOut   (pixelOut),
        .dataEnable (dataEnable),
        .hSyncOut   (hSyncOut),
        .vSyncOut   (vSyncOut),
        .underflow  (underflow)
    );

    // galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic abortRun(input string reason);
        $display("run aborted: %s", reason);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic idleCycles(input int count);
        repeat (count)
        begin
            @(posedge sysClk);
            writeEn <= 1'b0;
        end
    endtask

    // retries until the word goes in while full is low
    task automatic writePixel(input pixelT value);
        int   tries;
        logic done;
        tries = 0;
        done  = 1'b0;
        while (!done)
        begin
            @(posedge sysClk);
            writeEn <= 1'b1;
            pixelIn <= value;
            @(negedge sysClk);
            if (!full)
            begin
                done = 1'b1;
            end
            else
            begin
                // dropped at the coming edge so back off
                @(posedge sysClk);
                writeEn <= 1'b0;
                tries++;
                while (full && tries < 500)
                begin
                    @(negedge sysClk);
                    tries++;
                end
                if (tries >= 500)
                begin
                    abortRun("full kept blocking the write, the display side never drained");
                end
            end
        end
    endtask

    task automatic waitShown(input int target);
        int tries;
        tries = 0;
        while (monitor.shownCount < target && tries < 2000)
        begin
            @(posedge iPixelClk);
            tries++;
        end
        if (monitor.shownCount < target)
        begin
            abortRun($sformatf("only %0d of %0d pixels were shown", monitor.shownCount, target));
        end
    endtask

    task automatic waitFull();
        int tries;
        tries = 0;
        while (!full && tries < 100)
        begin
            @(negedge sysClk);
            tries++;
        end
        if (!full)
        begin
            abortRun("full did not rise after the fifo was filled");
        end
    endtask

    task automatic waitUnderflow();
        int tries;
        tries = 0;
        while (!underflow && tries < 500)
        begin
            @(posedge iPixelClk);
            tries++;
        end
        if (!underflow)
        begin
            abortRun("underflow never rose after writing stopped");
        end
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial
    begin
        reset   = 1'b1;
        writeEn = 1'b0;
        pixelIn = '0;
        lfsr    = 16'd16097;

        // nonzero low byte so blank pixels stand out
        for (int i = 0; i < tableSize; i++)
        begin
            stim[i].pixel = {8'(i * 29), 8'h5A, 8'(i + 1)};
            stim[i].phase = (i < fillCount) ? fillPhase : streamPhase;
            monitor.loadExpected(stim[i].pixel);
        end

        repeat (5) @(posedge iPixelClk);
        reset <= 1'b0;

        // fill back to back before any reads
        for (int i = 0; i < tableSize; i++)
        begin
            if (stim[i].phase == fillPhase)
            begin
                writePixel(stim[i].pixel);
            end
        end
        waitFull();

        // writes against a full fifo must vanish
        repeat (3)
        begin
            @(posedge sysClk);
            writeEn <= 1'b1;
            pixelIn <= blockedPixel;
        end
        idleCycles(1);

        // remaining words with random gaps
        for (int i = 0; i < tableSize; i++)
        begin
            if (stim[i].phase == streamPhase)
            begin
                lfsr = lfsrStep(lfsr);
                if (lfsr[0])
                begin
                    idleCycles(1);
                end
                writePixel(stim[i].pixel);
            end
        end
        @(posedge sysClk);
        writeEn <= 1'b0;
        pixelIn <= '0;
        monitor.endTest(1, "reset state");

        waitShown(tableSize);
        monitor.endTest(3, "pixel order");
        monitor.endTest(4, "full and blocked writes");

        // two starved lines after the table
        waitUnderflow();
        waitShown(tableSize + 16);
        monitor.endTest(5, "underflow");
        monitor.endTest(2, "sync timing");

        monitor.closeReport();
        if (monitor.failedTests == 0 && monitor.checkFails == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* test/displayPipeChecker.sv */
module displayPipeChecker #(
    parameter int hActive   = 8,
    parameter int hFront    = 2,
    parameter int hSync     = 2,
    parameter int hBack     = 2,
    parameter int vSync     = 1,
    parameter int fifoDepth = 16,
    parameter displayPkg::pixelT blockedPixel = 24'hDEAD00
)(
    input  logic              iPixelClk,
    input  logic              sysClk,
    input  logic              reset,
    input  displayPkg::pixelT pixelIn,
    input  logic              writeEn,
    input  logic              full,
    input  displayPkg::pixelT pixelOut,
    input  logic              dataEnable,
    input  logic              hSyncOut,
    input  logic              vSyncOut,
    input  logic              underflow
);
    timeunit 1ns;
    timeprecision 100ps;
    import displayPkg::*;

    localparam int lineLength = hActive + hFront + hSync + hBack;

    // expected display order as loaded by the testbench
    pixelT expQ[$];
    int    shownCount  = 0;
    int    errs[1:5]   = '{default: 0};
    int    testsRun    = 0;
    int    failedTests = 0;
    int    checkFails  = 0;
    int    writesTaken = 0;

    logic  firstDe  = 1'b0;
    logic  fullSeen = 1'b0;
    logic  prevH    = 1'b0;
    logic  prevDe   = 1'b0;
    logic  prevV    = 1'b0;
    logic  prevU    = 1'b0;
    int    cycle     = 0;
    int    lastHRise = -1;
    int    hRun      = 0;
    int    deRun     = 0;
    int    vRun      = 0;

    task automatic mismatch(input int id, input string msg);
        errs[id]++;
        checkFails++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic loadExpected(input pixelT value);
        expQ.push_back(value);
    endtask

    task automatic endTest(input int id, input string name);
        // full must have been seen at least once
        if (id == 4 && !fullSeen)
        begin
            mismatch(4, "full never went high");
        end
        testsRun++;
        if (errs[id] == 0)
        begin
            $display("test %0d %s: ok", id, name);
        end
        else
        begin
            failedTests++;
            $display("test %0d %s: failed, %0d errors", id, name, errs[id]);
        end
    endtask

    task automatic closeReport();
        $display("tests run %0d, tests failed %0d, check failures %0d",
            testsRun, failedTests, checkFails);
    endtask

    // ----------------------------------------
    // write side sampled mid cycle
    // ----------------------------------------
    always @(negedge sysClk)
    begin
        if (reset)
        begin
            writesTaken = 0;
        end
        else
        begin
            if (full)
            begin
                fullSeen = 1'b1;
                // full needs a whole depth of accepted writes
                if (writesTaken < fifoDepth)
                begin
                    mismatch(4, $sformatf("full high after only %0d writes", writesTaken));
                end
            end
            // blocked word would be taken at the next edge
            if (writeEn && !full && pixelIn == blockedPixel)
            begin
                mismatch(4, "blocked word accepted while not full");
            end
            if (writeEn && !full)
            begin
                writesTaken++;
            end
        end
    end

    // ----------------------------------------
    // display side sampled mid cycle
    // ----------------------------------------
    always @(negedge iPixelClk)
    begin
        if (reset)
        begin
            prevH     = 1'b0;
            prevDe    = 1'b0;
            prevV     = 1'b0;
            prevU     = 1'b0;
            hRun      = 0;
            deRun     = 0;
            vRun      = 0;
            lastHRise = -1;
            cycle     = 0;
        end
        else
        begin
            cycle++;
            if (dataEnable)
            begin
                firstDe = 1'b1;
            end
            // quiet outputs until the first window
            if (!firstDe && (hSyncOut || vSyncOut || underflow || pixelOut != '0))
            begin
                mismatch(1, "output active before first window");
            end

            // line period from hsync rise to rise
            if (hSyncOut && !prevH)
            begin
                if (lastHRise >= 0 && cycle - lastHRise != lineLength)
                begin
                    mismatch(2, $sformatf("line period %0d, expected %0d",
                        cycle - lastHRise, lineLength));
                end
                lastHRise = cycle;
            end
            if (hSyncOut)
            begin
                hRun++;
            end
            else
            begin
                if (prevH && hRun != hSync)
                begin
                    mismatch(2, $sformatf("hsync width %0d, expected %0d", hRun, hSync));
                end
                hRun = 0;
            end

            // active window width
            if (dataEnable)
            begin
                deRun++;
            end
            else
            begin
                if (prevDe && deRun != hActive)
                begin
                    mismatch(2, $sformatf("window width %0d, expected %0d", deRun, hActive));
                end
                deRun = 0;
            end

            // vsync spans whole lines
            if (vSyncOut)
            begin
                vRun++;
            end
            else
            begin
                if (prevV && vRun != vSync * lineLength)
                begin
                    mismatch(2, $sformatf("vsync length %0d, expected %0d",
                        vRun, vSync * lineLength));
                end
                vRun = 0;
            end

            // pixel order and then blank pixels once the table runs out
            if (dataEnable)
            begin
                if (shownCount < expQ.size())
                begin
                    if (pixelOut !== expQ[shownCount])
                    begin
                        mismatch(3, $sformatf("pixel %0d is %h, expected %h",
                            shownCount, pixelOut, expQ[shownCount]));
                    end
                    if (underflow)
                    begin
                        mismatch(5, "underflow while pixels were still due");
                    end
                end
                else
                begin
                    if (pixelOut !== '0)
                    begin
                        mismatch(5, $sformatf("starved pixel is %h, expected 0", pixelOut));
                    end
                    if (!underflow)
                    begin
                        mismatch(5, "underflow low on a starved pixel");
                    end
                end
                shownCount++;
            end
            // sticky until reset
            if (prevU && !underflow)
            begin
                mismatch(5, "underflow cleared without reset");
            end

            prevH  = hSyncOut;
            prevDe = dataEnable;
            prevV  = vSyncOut;
            prevU  = underflow;
        end
    end

endmodule

/* verilog/displayPipe.sv */
module displayPipe #(
    parameter int fifoDepth = 1024,
    parameter int hActive   = 640,
    parameter int hFront    = 16,
    parameter int hSync     = 96,
    parameter int hBack     = 48,
    parameter int vActive   = 480,
    parameter int vFront    = 10,
    parameter int vSync     = 2,
    parameter int vBack     = 33
)(
    input  logic              sysClk,
    input  logic              iPixelClk,
    input  logic              reset,
    input  displayPkg::pixelT pixelIn,
    input  logic              writeEn,
    output logic              full,
    output displayPkg::pixelT pixelOut,
    output logic              dataEnable,
    output logic              hSyncOut,
    output logic              vSyncOut,
    output logic              underflow
);

    // ----------------------------------------
    // fifo read side, pixel clock domain
    // ----------------------------------------
    fifoReadIf rdBus ();

    // system clock writes, pixel clock reads
    pixelFifo #(
        .fifoDepth (fifoDepth)
    ) pixelBuffer (
        .sysClk    (sysClk),
        .iPixelClk (iPixelClk),
        .reset     (reset),
        .pixelIn   (pixelIn),
        .writeEn   (writeEn),
        .full      (full),
        .rd        (rdBus.fifo),
        .pixelOut  (pixelOut)
    );

    // raster timing, pulls one pixel per active clock
    videoTimingCtrl #(
        .hActive (hActive),
        .hFront  (hFront),
        .hSync   (hSync),
        .hBack   (hBack),
        .vActive (vActive),
        .vFront  (vFront),
        .vSync   (vSync),
        .vBack   (vBack)
    ) timingCtrl (
        .iPixelClk  (iPixelClk),
        .reset      (reset),
        .rd         (rdBus.consumer),
        .dataEnable (dataEnable),
        .hSyncOut   (hSyncOut),
        .vSyncOut   (vSyncOut),
        .underflow  (underflow)
    );

endmodule

/* verilog/videoTimingCtrl.sv */
module videoTimingCtrl #(
    parameter int hActive = 640,
    parameter int hFront  = 16,
    parameter int hSync   = 96,
    parameter int hBack   = 48,
    parameter int vActive = 480,
    parameter int vFront  = 10,
    parameter int vSync   = 2,
    parameter int vBack   = 33
)(
    input  logic        iPixelClk,
    input  logic        reset,
    fifoReadIf.consumer rd,
    output logic        dataEnable,
    output logic        hSyncOut,
    output logic        vSyncOut,
    output logic        underflow
);
    import displayPkg::*;

    // vertical landmarks in lines
    localparam countT vLastLine   = countT'(vActive + vFront + vSync + vBack - 1);
    localparam countT vActiveEnd  = countT'(vActive);
    localparam countT vSyncStart  = countT'(vActive + vFront);
    localparam countT vSyncEnd    = countT'(vActive + vFront + vSync);

    timingStateT hState;
    timingStateT hStateNext;
    countT       hCount;
    countT       vCount;
    countT       stateLast;
    logic        stateEnd;
    logic        lineEnd;

    // raster held until the first pixel is in the fifo
    logic        running;
    // outputs enabled from the first line of a frame
    logic        primed;

    logic        fetch;
    logic        hSyncNow;
    logic        vSyncNow;
    logic        fetchD1;
    logic        hSyncD1;
    logic        vSyncD1;

    // ----------------------------------------
    // horizontal fsm
    // ----------------------------------------
    // last count of each phase
    always_comb
    begin
        case (hState)
            activeSt:     stateLast = countT'(hActive - 1);
            frontPorchSt: stateLast = countT'(hFront - 1);
            syncSt:       stateLast = countT'(hSync - 1);
            default:      stateLast = countT'(hBack - 1);
        endcase
    end

    always_comb
    begin
        case (hState)
            activeSt:     hStateNext = frontPorchSt;
            frontPorchSt: hStateNext = syncSt;
            syncSt:       hStateNext = backPorchSt;
            default:      hStateNext = activeSt;
        endcase
    end

    assign stateEnd = hCount == stateLast;
    assign lineEnd  = stateEnd && (hState == backPorchSt);

    // starts on the last blank line so the fifo fills first
    always_ff @(posedge iPixelClk)
    begin
        if (reset)
        begin
            hState  <= activeSt;
            hCount  <= '0;
            vCount  <= vLastLine;
            running <= 1'b0;
            primed  <= 1'b0;
        end
        else
        begin
            if (!rd.empty)
            begin
                running <= 1'b1;
            end
            if (running)
            begin
                if (stateEnd)
                begin
                    hState <= hStateNext;
                    hCount <= '0;
                end
                else
                begin
                    hCount <= hCount + 1'b1;
                end
                // line counter wraps at frame end
                if (lineEnd)
                begin
                    if (vCount == vLastLine)
                    begin
                        vCount <= '0;
                        primed <= 1'b1;
                    end
                    else
                    begin
                        vCount <= vCount + 1'b1;
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // raster decode and fetch
    // ----------------------------------------
    assign fetch    = primed && (hState == activeSt) && (vCount < vActiveEnd);
    assign hSyncNow = primed && (hState == syncSt);
    assign vSyncNow = primed && (vCount >= vSyncStart) && (vCount < vSyncEnd);

    // fifo answers next clock and the pixel register one later
    assign rd.readEn = fetch && !rd.empty;

    // two stages so syncs and enable meet pixelOut
    always_ff @(posedge iPixelClk)
    begin
        if (reset)
        begin
            fetchD1    <= 1'b0;
            hSyncD1    <= 1'b0;
            vSyncD1    <= 1'b0;
            dataEnable <= 1'b0;
            hSyncOut   <= 1'b0;
            vSyncOut   <= 1'b0;
            underflow  <= 1'b0;
        end
        else
        begin
            fetchD1    <= fetch;
            hSyncD1    <= hSyncNow;
            vSyncD1    <= vSyncNow;
            dataEnable <= fetchD1;
            hSyncOut   <= hSyncD1;
            vSyncOut   <= vSyncD1;
            // sticky once a due pixel does not come back
            if (fetchD1 && !rd.readValid)
            begin
                underflow <= 1'b1;
            end
        end
    end

    syncOutsideWindow: assert property (@(posedge iPixelClk) disable iff (reset)
        !(hSyncOut && dataEnable))
        else $error("hsync inside the active window");

endmodule

/* verilog/pixelFifo.sv */
module pixelFifo #(
    parameter int fifoDepth = 16
)(
    input  logic              sysClk,
    input  logic              iPixelClk,
    input  logic              reset,
    input  displayPkg::pixelT pixelIn,
    input  logic              writeEn,
    output logic              full,
    fifoReadIf.fifo           rd,
    output displayPkg::pixelT pixelOut
);
    import displayPkg::*;

    // pointers wrap at twice the depth, upper bits stay zero
    localparam ptrT ptrMask    = ptrT'(2 * fifoDepth - 1);
    localparam ptrT depthCount = ptrT'(fifoDepth);

    // depth must be a power of two that fits the pointer type
    if ((fifoDepth < 2) || ((fifoDepth & (fifoDepth - 1)) != 0)
        || (fifoDepth > 2 ** (ptrWidth - 1)))
    begin : depthCheck
        $error("fifoDepth must be a power of two between 2 and %0d", 2 ** (ptrWidth - 1));
    end

    // write domain
    ptrT  wrBin;
    ptrT  wrGray;
    ptrT  wrBinNext;
    ptrT  rdGraySync;
    ptrT  rdBinSync;
    ptrT  wrUsed;
    logic writeAccept;

    // read domain
    ptrT  rdBin;
    ptrT  rdGray;
    ptrT  rdBinNext;
    ptrT  wrGraySync;
    logic readAccept;

    function automatic ptrT grayToBin(input ptrT gray);
        ptrT bin;
        bin[ptrWidth-1] = gray[ptrWidth-1];
        for (int i = ptrWidth - 2; i >= 0; i--)
        begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    // ----------------------------------------
    // write side, sysClk
    // ----------------------------------------
    assign wrBinNext = (wrBin + 1'b1) & ptrMask;

    // read pointer as seen from here lags by the sync
    assign rdBinSync = grayToBin(rdGraySync);
    assign wrUsed    = (wrBin - rdBinSync) & ptrMask;

    // full once fifoDepth words are in flight
    assign full        = wrUsed == depthCount;
    // writes while full are dropped
    assign writeAccept = writeEn && !full;

    always_ff @(posedge sysClk)
    begin
        if (reset)
        begin
            wrBin  <= '0;
            wrGray <= '0;
        end
        else if (writeAccept)
        begin
            wrBin  <= wrBinNext;
            wrGray <= wrBinNext ^ (wrBinNext >> 1);
        end
    end

    // ----------------------------------------
    // read side, iPixelClk
    // ----------------------------------------
    assign rdBinNext = (rdBin + 1'b1) & ptrMask;

    // equal gray pointers, nothing left to read
    assign rd.empty  = rdGray == wrGraySync;
    // readEn while empty is ignored
    assign readAccept = rd.readEn && !rd.empty;

    always_ff @(posedge iPixelClk)
    begin
        if (reset)
        begin
            rdBin        <= '0;
            rdGray       <= '0;
            rd.readValid <= 1'b0;
        end
        else
        begin
            // valid together with the ram output
            rd.readValid <= readAccept;
            if (readAccept)
            begin
                rdBin  <= rdBinNext;
                rdGray <= rdBinNext ^ (rdBinNext >> 1);
            end
        end
    end

    // pixel output register, loaded by the read strobe
    // blank when no pixel arrives
    always_ff @(posedge iPixelClk)
    begin
        if (reset)
        begin
            pixelOut <= '0;
        end
        else if (rd.readValid)
        begin
            pixelOut <= rd.readData;
        end
        else
        begin
            pixelOut <= '0;
        end
    end

    // ----------------------------------------
    // ram and pointer crossings
    // ----------------------------------------
    pixelFifoMem #(
        .fifoDepth (fifoDepth)
    ) fifoMem (
        .writeClk  (sysClk),
        .writeEn   (writeAccept),
        .writeAddr (wrBin),
        .writeData (pixelIn),
        .iPixelClk (iPixelClk),
        .readEn    (readAccept),
        .readAddr  (rdBin),
        .readData  (rd.readData)
    );

    // write pointer into the pixel domain, drives empty
    grayPtrSync wrPtrSync (
        .clk     (iPixelClk),
        .reset   (reset),
        .grayIn  (wrGray),
        .grayOut (wrGraySync)
    );

    // read pointer into the system domain, drives full
    grayPtrSync rdPtrSync (
        .clk     (sysClk),
        .reset   (reset),
        .grayIn  (rdGray),
        .grayOut (rdGraySync)
    );

    // occupancy seen by the writer never passes the depth
    fillBound: assert property (@(posedge sysClk) disable iff (reset) wrUsed <= depthCount)
        else $error("fifo overfilled, write accepted while full");

    // the consumer keeps to the empty rule of the interface
    readRule: assert property (@(posedge iPixelClk) disable iff (reset) rd.readEn |-> !rd.empty)
        else $error("read requested while fifo empty");

endmodule

/* verilog/grayPtrSync.sv */
module grayPtrSync (
    input  logic            clk,
    input  logic            reset,
    input  displayPkg::ptrT grayIn,
    output displayPkg::ptrT grayOut
);
    import displayPkg::*;

    // first stage may go metastable
    ptrT stage1;

    // two flops in the destination domain
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stage1  <= '0;
            grayOut <= '0;
        end
        else
        begin
            stage1  <= grayIn;
            grayOut <= stage1;
        end
    end

    // gray code steps one bit at a time in the source domain
    // sampled on every change, since the source clock may be faster
    // a multi-bit step could be captured half old, half new
    property grayOneBitStep;
        @(grayIn) disable iff (reset)
            $countones(grayIn ^ $past(grayIn)) <= 1;
    endproperty

    grayStepCheck: assert property (grayOneBitStep)
        else $error("gray pointer moved more than one bit");

endmodule

/* verilog/pixelFifoMem.sv */
module pixelFifoMem #(
    parameter int fifoDepth = 16
)(
    input  logic              writeClk,
    input  logic              writeEn,
    input  displayPkg::ptrT   writeAddr,
    input  displayPkg::pixelT writeData,
    input  logic              iPixelClk,
    input  logic              readEn,
    input  displayPkg::ptrT   readAddr,
    output displayPkg::pixelT readData
);
    import displayPkg::*;

    // the wrap bit and any unused upper bits are dropped
    localparam int addrBits = $clog2(fifoDepth);

    // block ram, no reset on the array
    pixelT ram [fifoDepth];

    // ----------------------------------------
    // write port, system clock
    // ----------------------------------------
    always_ff @(posedge writeClk)
    begin
        if (writeEn)
        begin
            ram[writeAddr[addrBits-1:0]] <= writeData;
        end
    end

    // ----------------------------------------
    // read port, pixel clock
    // ----------------------------------------
    // registered output, holds between reads
    always_ff @(posedge iPixelClk)
    begin
        if (readEn)
        begin
            readData <= ram[readAddr[addrBits-1:0]];
        end
    end

endmodule

/* verilog/fifoReadIf.sv */
interface fifoReadIf;
    import displayPkg::*;

    // request from the consumer, only while empty is low
    logic  readEn;
    // word from the fifo ram, one clock after readEn
    pixelT readData;
    // accepted read, registered
    logic  readValid;
    // read side view of the fill level
    logic  empty;

    modport fifo (
        input  readEn,
        output readData,
        output readValid,
        output empty
    );

    modport consumer (
        output readEn,
        input  readData,
        input  readValid,
        input  empty
    );

endinterface

/* verilog/displayPkg.sv */
package displayPkg;

    // ----------------------------------------
    // pixel word
    // ----------------------------------------

    // one rgb pixel, 8 bits per colour
    parameter int pixelWidth = 24;

    typedef logic [pixelWidth-1:0] pixelT;

    // ----------------------------------------
    // fifo pointers
    // ----------------------------------------

    // address bits plus one wrap bit
    // fifoDepth may not exceed 2**(ptrWidth-1)
    parameter int ptrWidth = 11;

    // same type for binary and gray pointers
    typedef logic [ptrWidth-1:0] ptrT;

    // ----------------------------------------
    // raster timing
    // ----------------------------------------

    // wide enough for pixels per line and lines per frame
    parameter int countWidth = 12;

    typedef logic [countWidth-1:0] countT;

    // horizontal phases of one line, in raster order
    typedef enum logic [1:0] {
        activeSt,
        frontPorchSt,
        syncSt,
        backPorchSt
    } timingStateT;

endpackage
